/* Bender.yml */
package:
  name: cmd_loader

sources:
  - loader_pkg.sv
  - memory_clear.sv
  - cmd_record_parser.sv
  - loader_sequencer.sv
  - cmd_loader.sv
  - target: test
    files:
      - loader_chk.sv
      - tb_cmd_loader.sv

/* cmd_loader.sv */
`timescale 1ns/1ns
//**********************************************************
// cmd file loader top level
//   loader_sequencer   session control and bus ownership
//   cmd_record_parser  record chain to ram writes
//   memory_clear       zero fill with the cls routine
//**********************************************************
module cmd_loader import loader_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cpum1,           // z80 opcode fetch, active low
    input  logic                  erase_mem,       // request a memory clear
    input  logic                  auto_run,        // jump to the transfer address
    input  host_byte_t            host,
    output logic                  ioctl_wait,      // host back-pressure
    output logic                  loader_download, // bus grant, cpu held
    output mem_write_t            loader_write,
    output logic [addr_width-1:0] execute_addr,
    output logic                  execute_enable   // one cycle jump request
);

    mem_write_t            parse_write;
    logic                  parse_start;
    logic                  parse_done;
    logic                  xfer_valid;
    logic [addr_width-1:0] xfer_addr;
    mem_write_t            clear_write;
    logic                  clear_start;
    logic                  clear_done;

    loader_sequencer i_loader_sequencer (
        .clock           (clock),
        .reset           (reset),
        .cpum1           (cpum1),
        .erase_mem       (erase_mem),
        .auto_run        (auto_run),
        .host            (host),
        .parse_write     (parse_write),
        .parse_done      (parse_done),
        .xfer_valid      (xfer_valid),
        .xfer_addr       (xfer_addr),
        .clear_write     (clear_write),
        .clear_done      (clear_done),
        .ioctl_wait      (ioctl_wait),
        .loader_download (loader_download),
        .loader_write    (loader_write),
        .execute_addr    (execute_addr),
        .execute_enable  (execute_enable),
        .parse_start     (parse_start),
        .clear_start     (clear_start)
    );

    cmd_record_parser i_cmd_record_parser (
        .clock       (clock),
        .reset       (reset),
        .parse_start (parse_start),
        .host        (host),
        .parse_write (parse_write),
        .parse_done  (parse_done),
        .xfer_valid  (xfer_valid),
        .xfer_addr   (xfer_addr)
    );

    memory_clear i_memory_clear (
        .clock       (clock),
        .reset       (reset),
        .clear_start (clear_start),
        .clear_write (clear_write),
        .clear_done  (clear_done)
    );

endmodule

/* cmd_record_parser.sv */
`timescale 1ns/1ns
//**********************************************************
// cmd record chain parser
//   type, length and load address of each record
//   payload bytes to consecutive ram writes
//   transfer address capture and end of file detection
//   first byte parking when it arrives before the grant
//**********************************************************
module cmd_record_parser import loader_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  parse_start,  // restart at the first type byte
    input  host_byte_t            host,
    output mem_write_t            parse_write,
    output logic                  parse_done,   // file ended
    output logic                  xfer_valid,   // transfer record seen
    output logic [addr_width-1:0] xfer_addr
);

    typedef enum logic [2:0] {
        p_idle, p_type, p_len, p_lsb, p_msb, p_data, p_skip
    } parse_state_t;

    parse_state_t          state;
    parse_state_t          cur;         // state this cycle's byte is parsed in
    logic [7:0]            rec_type;
    logic [8:0]            count;       // payload or skip bytes left
    logic [addr_width-1:0] rec_addr;    // next payload address
    logic                  at_start;    // session started, no byte taken yet
    logic [data_width-1:0] held_data;   // first byte seen before the bus grant
    logic                  held_valid;
    logic                  new_file;
    logic                  take;        // a byte is parsed this cycle
    logic [data_width-1:0] din;

    // an offset 0 byte outside a fresh session starts a new file
    assign new_file = host.wr && (host.addr == 24'd0) && cmd_index_match(host.index)
                      && !at_start;

    always_comb begin
        cur  = parse_start ? p_type : state;
        take = parse_start ? held_valid : host.wr;     // parked byte goes first
        din  = parse_start ? held_data : host.data;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= p_idle;
            rec_type    <= '0;
            count       <= '0;
            rec_addr    <= '0;
            at_start    <= 1'b0;
            held_data   <= '0;
            held_valid  <= 1'b0;
            parse_write <= '0;
            parse_done  <= 1'b0;
            xfer_valid  <= 1'b0;
            xfer_addr   <= '0;
        end else begin
            parse_write.wr <= 1'b0;
            parse_done     <= 1'b0;
            if (new_file) begin
                held_data  <= host.data;  // wait here for parse_start
                held_valid <= 1'b1;
                state      <= p_idle;
            end else begin
                state <= cur;
                if (parse_start) begin
                    held_valid <= 1'b0;
                    xfer_valid <= 1'b0;
                    at_start   <= 1'b1;
                end
                if (take) begin
                    at_start <= 1'b0;
                    case (cur)
                        p_type: begin
                            rec_type <= din;
                            if (din == rec_eof) begin
                                parse_done <= 1'b1;
                                state      <= p_idle;
                            end else begin
                                state <= p_len;
                            end
                        end
                        p_len: begin
                            state <= p_lsb;
                            if (rec_type == rec_data) begin
                                // 0, 1 and 2 wrap to 254, 255 and 256 bytes
                                count <= (din < 8'd3) ? {1'b0, din} + 9'd254
                                                      : {1'b0, din} - 9'd2;
                            end else if (rec_type == rec_xfer) begin
                                count <= (din > 8'd2) ? {1'b0, din} - 9'd2 : 9'd0;
                            end else begin  // unknown record, skip its body
                                count <= {1'b0, din};
                                state <= (din == 8'd0) ? p_type : p_skip;
                            end
                        end
                        p_lsb: begin
                            rec_addr[7:0] <= din;
                            state         <= p_msb;
                        end
                        p_msb: begin
                            rec_addr[addr_width-1:8] <= din;
                            if (rec_type == rec_data) begin
                                state <= p_data;
                            end else begin
                                xfer_addr  <= {din, rec_addr[7:0]};
                                xfer_valid <= 1'b1;
                                if (count == 9'd0) begin  // nothing trails the address
                                    parse_done <= 1'b1;
                                    state      <= p_idle;
                                end else begin
                                    state <= p_skip;
                                end
                            end
                        end
                        p_data: begin
                            parse_write <= '{wr: 1'b1, addr: rec_addr, data: din};
                            rec_addr    <= rec_addr + 1'b1;
                            count       <= count - 9'd1;
                            if (count == 9'd1) state <= p_type;
                        end
                        p_skip: begin
                            count <= count - 9'd1;
                            if (count == 9'd1) begin
                                // a transfer record always closes the file
                                if (rec_type == rec_xfer) begin
                                    parse_done <= 1'b1;
                                    state      <= p_idle;
                                end else begin
                                    state <= p_type;
                                end
                            end
                        end
                        default: ;  // stray bytes while idle
                    endcase
                end
            end
        end
    end

endmodule

/* loader_chk.sv */
`timescale 1ns/1ns
//**********************************************************
// bound checks on the cmd_loader ports
//   ram writes only while the bus is granted
//   single cycle execute request
//   bus grant only after an opcode fetch
//**********************************************************
module loader_chk import loader_pkg::*; (
    input logic       clock,
    input logic       reset,
    input logic       cpum1,
    input logic       loader_download,
    input mem_write_t loader_write,
    input logic       execute_enable
);

    write_in_grant: assert property (@(posedge clock) disable iff (reset)
        loader_write.wr |-> loader_download)
        else $error("ram write while the cpu owns the bus");

    // jump request is a pulse
    execute_pulse: assert property (@(posedge clock) disable iff (reset)
        execute_enable |=> !execute_enable)
        else $error("execute_enable high for two cycles");

    grant_after_m1: assert property (@(posedge clock) disable iff (reset)
        $rose(loader_download) |-> !$past(cpum1))
        else $error("bus taken without an opcode fetch");

endmodule

bind cmd_loader loader_chk i_loader_chk (.*);

/* loader_pkg.sv */
//**********************************************************
// shared definitions of the cmd file loader
//   bus widths and the host menu slot of cmd files
//   record type codes of the cmd record chain
//   memory map of the clear sweep and its screen clear code
//   host stream and ram write structs
//**********************************************************
package loader_pkg;

    localparam int data_width = 8;   // one ram byte
    localparam int addr_width = 16;  // z80 address space

    localparam logic [5:0] cmd_menu_index = 6'd2;  // menu slot of /cmd files

    // type byte at the head of every record
    localparam logic [7:0] rec_eof  = 8'd0;
    localparam logic [7:0] rec_data = 8'd1;
    localparam logic [7:0] rec_xfer = 8'd2;  // carries the entry point

    localparam logic [addr_width-1:0] clear_base  = 16'h4000;  // first ram byte above rom
    localparam logic [addr_width-1:0] clear_top   = 16'hffff;
    localparam logic [addr_width-1:0] clear_entry = 16'hffe1;  // routine start and jump target

    // screen clear routine that fills video ram 3c00..3fff with spaces
    // the two operand bytes of the final jp come from the zero fill
    localparam logic [data_width-1:0] clear_code [16] = '{
        8'hf3,                // di
        8'h21, 8'h00, 8'h3c,  // ld hl,3c00h
        8'h11, 8'h01, 8'h3c,  // ld de,3c01h
        8'h3e, 8'h20,         // ld a,20h
        8'h77,                // ld (hl),a
        8'h01, 8'hff, 8'h03,  // ld bc,03ffh
        8'hed, 8'hb0,         // ldir
        8'hc3                 // jp 0000h
    };

    // one cycle of the host file stream
    typedef struct packed {
        logic                  download;  // high for the whole file
        logic                  wr;        // byte strobe
        logic [15:0]           index;     // menu index of the file
        logic [23:0]           addr;      // byte offset in the file
        logic [data_width-1:0] data;
    } host_byte_t;

    // one ram write request
    typedef struct packed {
        logic                  wr;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } mem_write_t;

    // low six bits pick the slot and the upper ten must be clear
    function automatic logic cmd_index_match(input logic [15:0] index);
        return (index[5:0] == cmd_menu_index) && (index[15:6] == 10'd0);
    endfunction

endpackage

/* loader_sequencer.sv */
`timescale 1ns/1ns
//**********************************************************
// loader session control
//   file start detection and host back-pressure
//   m1 wait before taking the memory bus
//   write source selection and the registered ram port
//   abort on download loss and the execute request
//**********************************************************
module loader_sequencer import loader_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cpum1,
    input  logic                  erase_mem,
    input  logic                  auto_run,
    input  host_byte_t            host,
    input  mem_write_t            parse_write,
    input  logic                  parse_done,
    input  logic                  xfer_valid,
    input  logic [addr_width-1:0] xfer_addr,
    input  mem_write_t            clear_write,
    input  logic                  clear_done,
    output logic                  ioctl_wait,
    output logic                  loader_download,
    output mem_write_t            loader_write,
    output logic [addr_width-1:0] execute_addr,
    output logic                  execute_enable,
    output logic                  parse_start,
    output logic                  clear_start
);

    typedef enum logic [2:0] {
        s_idle,
        s_wait_load,   // file seen, waiting for an opcode fetch
        s_wait_clear,  // clear requested, waiting for an opcode fetch
        s_load,
        s_clear,
        s_release      // hand the bus back to the cpu
    } seq_state_t;

    seq_state_t state;
    logic       clear_session;  // this session is a clear
    logic       file_start;     // first byte offset of a cmd file

    assign file_start = host.download && (host.addr == 24'd0) && cmd_index_match(host.index);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state           <= s_idle;
            clear_session   <= 1'b0;
            ioctl_wait      <= 1'b0;
            loader_download <= 1'b0;
            loader_write    <= '0;
            execute_addr    <= '0;
            execute_enable  <= 1'b0;
            parse_start     <= 1'b0;
            clear_start     <= 1'b0;
        end else begin
            loader_write.wr <= 1'b0;  // one write per cycle at most
            execute_enable  <= 1'b0;
            parse_start     <= 1'b0;
            clear_start     <= 1'b0;
            case (state)
                s_idle: begin
                    if (file_start) begin
                        ioctl_wait    <= 1'b1;  // hold the stream until the bus is ours
                        clear_session <= 1'b0;
                        state         <= s_wait_load;
                    end else if (erase_mem) begin
                        clear_session <= 1'b1;
                        state         <= s_wait_clear;
                    end
                end
                s_wait_load: begin
                    if (!host.download) begin  // file dropped before the grant
                        ioctl_wait <= 1'b0;
                        state      <= s_idle;
                    end else if (!cpum1) begin
                        loader_download <= 1'b1;  // only safe during m1
                        parse_start     <= 1'b1;
                        state           <= s_load;
                    end
                end
                s_wait_clear: begin
                    if (!cpum1) begin
                        loader_download <= 1'b1;
                        clear_start     <= 1'b1;
                        state           <= s_clear;
                    end
                end
                s_load: begin
                    ioctl_wait <= 1'b0;  // let the rest of the file flow
                    if (parse_done) begin
                        if (auto_run && xfer_valid) begin
                            execute_enable <= 1'b1;
                            execute_addr   <= xfer_addr;
                        end
                        state <= s_release;
                    end else if (!host.download) begin
                        // host gave up mid file, free the cpu with no jump
                        loader_download <= 1'b0;
                        state           <= s_idle;
                    end else begin
                        loader_write <= parse_write;
                    end
                end
                s_clear: begin
                    loader_write <= clear_write;
                    if (clear_done) begin
                        execute_enable <= 1'b1;
                        execute_addr   <= clear_entry;  // run the cls routine
                        state          <= s_release;
                    end
                end
                s_release: begin
                    // a clear keeps the bus until the request pulse ends
                    if (!clear_session || !erase_mem) begin
                        loader_download <= 1'b0;
                        state           <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

/* memory_clear.sv */
`timescale 1ns/1ns
//**********************************************************
// memory clear sweep
//   one write per cycle from clear_base up to clear_top
//   cls routine bytes planted from clear_entry on
//**********************************************************
module memory_clear import loader_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       clear_start,
    output mem_write_t clear_write,
    output logic       clear_done   // pulses with the last write
);

    logic                  active;      // sweep running
    logic [addr_width-1:0] sweep_addr;
    logic [addr_width-1:0] offset;      // distance past the routine entry
    logic [data_width-1:0] fill;

    assign offset = sweep_addr - clear_entry;
    // below the entry the subtraction wraps high so only 16 bytes hit the table
    assign fill = (offset[addr_width-1:4] == '0) ? clear_code[offset[3:0]] : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active      <= 1'b0;
            sweep_addr  <= clear_base;
            clear_write <= '0;
            clear_done  <= 1'b0;
        end else begin
            clear_write.wr <= 1'b0;
            clear_done     <= 1'b0;
            if (clear_start) begin
                active     <= 1'b1;
                sweep_addr <= clear_base;
            end else if (active) begin
                clear_write <= '{wr: 1'b1, addr: sweep_addr, data: fill};
                sweep_addr  <= sweep_addr + 1'b1;
                if (sweep_addr == clear_top) begin  // top of ram reached
                    active     <= 1'b0;
                    clear_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* src.f */
loader_pkg.sv
memory_clear.sv
cmd_record_parser.sv
loader_sequencer.sv
cmd_loader.sv
loader_chk.sv
tb_cmd_loader.sv

/* tb_cmd_loader.sv */
`timescale 1ns/1ns
//**********************************************************
// testbench of the cmd file loader
//   random cmd files built record by record
//   host stream driver with m1 gating and abort
//   expected write queue, ram model and execute checks
//   memory clear sweep check and closing report
//**********************************************************
module tb_cmd_loader import loader_pkg::*; ();

    logic        clock;
    logic        reset;
    logic        cpum1;
    logic        erase_mem;
    logic        auto_run;
    host_byte_t  host;
    logic        ioctl_wait;
    logic        loader_download;
    mem_write_t  loader_write;
    logic [15:0] execute_addr;
    logic        execute_enable;

    logic [7:0]  file_q [$];                  // bytes of the file being sent
    logic [23:0] wq [$];                      // expected writes in order, addr and data
    logic [7:0]  expect_mem [logic [15:0]];   // expected final ram contents
    logic [7:0]  ram [logic [15:0]];          // what the dut wrote
    // di, ld hl,3c00h, ld de,3c01h, ld a,20h, ld (hl),a, ld bc,03ffh, ldir, jp
    logic [7:0]  cls_table [16] = '{8'hf3, 8'h21, 8'h00, 8'h3c, 8'h11, 8'h01, 8'h3c, 8'h3e,
                                    8'h20, 8'h77, 8'h01, 8'hff, 8'h03, 8'hed, 8'hb0, 8'hc3};
    int          write_budget;                // payload writes the model still expects
    bit          has_xfer;                    // file ends in a transfer record
    logic [15:0] xfer_target;
    int          exec_count;
    logic [15:0] exec_addr_seen;
    int          mismatch_count;
    int          other_count;
    int          cycle_count;
    int          limit = 1000 + 49152;        // one clear sweep, file bytes added later

    cmd_loader i_cmd_loader (.*);

    always #20 clock = ~clock;

    always @(posedge clock) cycle_count++;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;  // inputs change just after the edge
    endtask

    task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
        wq.push_back({a, d});
        expect_mem[a] = d;
    endtask

    // type 1 record, length byte n, random load address and payload
    task automatic add_data_record(input logic [7:0] n);
        logic [15:0] a;
        logic [7:0]  d;
        int          count;
        a = 16'($urandom);
        count = (n == 8'd2) ? 256 : (n == 8'd1) ? 255 : (n == 8'd0) ? 254 : n - 2;
        file_q.push_back(8'h01);
        file_q.push_back(n);
        file_q.push_back(a[7:0]);
        file_q.push_back(a[15:8]);
        repeat (count) begin
            d = 8'($urandom);
            file_q.push_back(d);
            if (write_budget > 0) begin
                expect_write(a, d);
                write_budget--;
            end
            a++;  // wraps at the top of the address space
        end
    endtask

    task automatic build_file(input int n_rec, input bit fixed_lens, input bit end_xfer);
        logic [7:0] t;
        logic [7:0] n;
        file_q.delete();
        write_budget = 1 << 20;
        for (int r = 0; r < n_rec; r++) begin
            if (fixed_lens && r < 3) begin
                add_data_record(8'(r));  // lengths 0, 1 and 2 wrap to long records
            end else if ($urandom_range(2) == 0) begin
                t = 8'($urandom_range(255, 3));  // unknown type, body skipped
                n = 8'($urandom_range(6));
                file_q.push_back(t);
                file_q.push_back(n);
                repeat (n) file_q.push_back(8'($urandom));
            end else begin
                add_data_record(8'($urandom_range(40, 3)));
            end
        end
        has_xfer = end_xfer;
        if (end_xfer) begin
            n = 8'($urandom_range(8, 2));
            xfer_target = 16'($urandom);
            file_q.push_back(8'h02);
            file_q.push_back(n);
            file_q.push_back(xfer_target[7:0]);
            file_q.push_back(xfer_target[15:8]);
            if (n > 8'd2) repeat (n - 2) file_q.push_back(8'($urandom));
        end else begin
            file_q.push_back(8'h00);  // eof
        end
        limit += 4 * file_q.size();
    endtask

    // sends send_count bytes of file_q, drops download early when short of the file
    task automatic run_file(input bit run, input int send_count);
        int execs;
        int i;
        bit exp_exec;
        execs = exec_count;
        exp_exec = run && has_xfer && (send_count == file_q.size());
        auto_run = run;
        host.download = 1'b1;
        host.index = 16'd2;
        host.addr = 24'd0;
        host.data = file_q[0];
        host.wr = 1'b1;
        next_cycle();
        host.wr = 1'b0;
        compare("ioctl_wait", ioctl_wait, 1);
        repeat ($urandom_range(20)) begin  // cpu busy, no opcode fetch yet
            compare("loader_download", loader_download, 0);
            next_cycle();
        end
        cpum1 = 1'b0;
        next_cycle();
        cpum1 = 1'b1;
        compare("loader_download", loader_download, 1);
        i = 1;
        while (i < send_count) begin
            if (!ioctl_wait && $urandom_range(3) != 0) begin
                host.wr = 1'b1;
                host.addr = 24'(i);
                host.data = file_q[i];
                i++;
            end else begin
                host.wr = 1'b0;
            end
            next_cycle();
        end
        host.wr = 1'b0;
        if (send_count < file_q.size()) begin
            repeat (2) next_cycle();  // let the last payload write out
            host.download = 1'b0;
        end
        while (loader_download) next_cycle();
        host.download = 1'b0;
        compare("writes left", wq.size(), 0);
        compare("execute pulses", exec_count - execs, exp_exec);
        if (exp_exec) compare("execute_addr", exec_addr_seen, xfer_target);
        next_cycle();
    endtask

    task automatic run_clear();
        int          execs;
        logic [15:0] a;
        execs = exec_count;
        for (int i = 0; i < 49152; i++) begin
            a = 16'h4000 + 16'(i);
            if (a >= 16'hffe1 && a <= 16'hfff0) expect_write(a, cls_table[a - 16'hffe1]);
            else expect_write(a, 8'h00);
        end
        erase_mem = 1'b1;
        next_cycle();
        repeat ($urandom_range(20)) begin
            compare("loader_download", loader_download, 0);
            next_cycle();
        end
        cpum1 = 1'b0;
        next_cycle();
        cpum1 = 1'b1;
        compare("loader_download", loader_download, 1);
        while (exec_count == execs) next_cycle();
        compare("execute_addr", exec_addr_seen, 16'hffe1);
        compare("writes left", wq.size(), 0);
        repeat (3) begin  // bus stays taken while erase_mem is high
            next_cycle();
            compare("loader_download", loader_download, 1);
        end
        erase_mem = 1'b0;
        while (loader_download) next_cycle();
        compare("execute pulses", exec_count - execs, 1);
    endtask

    // write monitor against the expected queue, plus the execute pulse log
    always @(negedge clock) begin
        if (!reset && loader_write.wr) begin
            if (wq.size() == 0) begin
                other_count++;
                $display("ERROR at %0t: ram write to %h with none expected",
                         $time, loader_write.addr);
            end else begin
                compare("loader_write.addr", loader_write.addr, wq[0][23:8]);
                compare("loader_write.data", loader_write.data, wq[0][7:0]);
                wq.delete(0);
            end
            ram[loader_write.addr] = loader_write.data;
        end
        if (!reset && execute_enable) begin
            exec_count++;
            exec_addr_seen = execute_addr;
        end
    end

    initial begin
        while (cycle_count <= limit) @(posedge clock);
        $display("ERROR: run did not finish within %0d cycles", limit);
        $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_count + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int k;
        k = $urandom(32'hcd4f_e58f);
        clock = 1'b0;
        reset = 1'b1;
        cpum1 = 1'b1;
        erase_mem = 1'b0;
        auto_run = 1'b0;
        host = '0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        next_cycle();
        compare("ioctl_wait", ioctl_wait, 0);  // all quiet out of reset
        compare("loader_download", loader_download, 0);
        compare("execute_enable", execute_enable, 0);
        compare("loader_write.wr", loader_write.wr, 0);

        build_file(5, 1'b1, 1'b0);  // fixed lengths, ends in eof so no jump
        run_file(1'b1, file_q.size());
        build_file(4, 1'b0, 1'b1);  // skips and data, transfer record
        run_file(1'b1, file_q.size());
        build_file(3, 1'b0, 1'b1);  // auto_run low
        run_file(1'b0, file_q.size());
        repeat (4) begin
            build_file($urandom_range(6, 1), 1'b0, 1'($urandom_range(1)));
            run_file(1'($urandom_range(1)), file_q.size());
        end

        // abort in the middle of a data record
        k = $urandom_range(20, 1);
        file_q.delete();
        write_budget = k;
        add_data_record(8'd40);
        has_xfer = 1'b0;
        limit += 4 * file_q.size();
        run_file(1'b1, 4 + k);
        build_file(2, 1'b0, 1'b1);  // next file after the abort
        run_file(1'b1, file_q.size());

        run_clear();

        foreach (expect_mem[a]) begin
            if (!ram.exists(a)) begin
                other_count++;
                $display("ERROR: address %h was never written", a);
            end else begin
                compare($sformatf("ram[%h]", a), ram[a], expect_mem[a]);
            end
        end

        $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
